//--- src/mul_cfg_pkg.sv
////////////////////////////////////////////////////////////
// Multiplier configuration
// Operand, partial product, product and pipeline sizes
////////////////////////////////////////////////////////////

package mul_cfg_pkg;

  // Operand width, multiplicand and multiplier alike
  localparam int MUL_W = 16;

  // One partial product row
  // Extended operand plus one bit for the x2 magnitude
  localparam int EXT_W = MUL_W + 2;

  // Full product width
  localparam int PROD_W = 2 * MUL_W;

  // Booth digits over the extended multiplier
  // The extra digit covers the top bits of an unsigned operand
  localparam int PP_NUM = MUL_W / 2 + 1;

  // Rows into the tree, partial products plus correction row
  localparam int ROW_NUM = PP_NUM + 1;

  // Register stages between operands and product
  localparam int PIPE_DEPTH = 2;

endpackage

//--- src/booth_pkg.sv
////////////////////////////////////////////////////////////
// Radix-4 Booth digit encoding
// Digit field layout, magnitude codes and window decoder
////////////////////////////////////////////////////////////

package booth_pkg;

  // Digit field is {neg, two, one}
  localparam int DIGIT_W = 3;

  // Negate flag position inside a digit field
  localparam int DIGIT_NEG = 2;

  // Magnitude select codes, low two bits of a digit
  localparam logic [1:0] SEL_ZERO = 2'b00;
  localparam logic [1:0] SEL_ONE  = 2'b01;
  localparam logic [1:0] SEL_TWO  = 2'b10;

  // Recode one 3-bit window {b[2i+1], b[2i], b[2i-1]}
  function automatic logic [DIGIT_W-1:0] encode_digit(input logic [2:0] win);
    logic [DIGIT_W-1:0] dig;
    dig = {DIGIT_W{1'b0}};
    case (win)
      3'b001, 3'b010: dig[1:0] = SEL_ONE;
      3'b011, 3'b100: dig[1:0] = SEL_TWO;
      3'b101, 3'b110: dig[1:0] = SEL_ONE;
      default:        dig[1:0] = SEL_ZERO;
    endcase
    // 111 is a zero digit, keep it positive
    dig[DIGIT_NEG] = win[2] & ~(win[1] & win[0]);
    return dig;
  endfunction

endpackage

//--- src/booth4_pp_gen.sv
////////////////////////////////////////////////////////////
// Booth partial product generator
// Radix-4 recoding and partial product rows plus correction
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module booth4_pp_gen (
  input  logic [mul_cfg_pkg::MUL_W-1:0]                          op_a,
  input  logic [mul_cfg_pkg::MUL_W-1:0]                          op_b,
  input  logic                                                   a_signed,
  input  logic                                                   b_signed,
  output logic [mul_cfg_pkg::ROW_NUM-1:0][mul_cfg_pkg::EXT_W-1:0] pp_rows
);

  ////////////////////////////////////////////////////////////
  // Operand extension
  ////////////////////////////////////////////////////////////

  // Multiplicand with one extra sign or zero bit
  logic [mul_cfg_pkg::MUL_W:0]   a_ext;
  // x1 and x2 magnitudes at full row width
  logic [mul_cfg_pkg::EXT_W-1:0] a_x1;
  logic [mul_cfg_pkg::EXT_W-1:0] a_x2;
  // Multiplier windows source, two sign copies on top and implicit zero below
  logic [mul_cfg_pkg::MUL_W+2:0] b_win;
  logic                          b_top;

  // Decoded digits, also observed by the assertions
  logic [mul_cfg_pkg::PP_NUM-1:0][booth_pkg::DIGIT_W-1:0] digits;

  assign a_ext = {a_signed & op_a[mul_cfg_pkg::MUL_W-1], op_a};
  assign a_x1  = {a_ext[mul_cfg_pkg::MUL_W], a_ext};
  assign a_x2  = {a_ext, 1'b0};

  assign b_top = b_signed & op_b[mul_cfg_pkg::MUL_W-1];
  assign b_win = {b_top, b_top, op_b, 1'b0};

  ////////////////////////////////////////////////////////////
  // Recoding and row forming
  ////////////////////////////////////////////////////////////

  always_comb begin : form_rows
    logic [mul_cfg_pkg::EXT_W-1:0] mag;
    logic [mul_cfg_pkg::EXT_W-1:0] row_val;
    pp_rows = '0;
    for (int i = 0; i < mul_cfg_pkg::PP_NUM; i++) begin
      // Overlapping windows, stride 2
      digits[i] = booth_pkg::encode_digit(b_win[2*i +: 3]);

      case (digits[i][booth_pkg::DIGIT_NEG-1:0])
        booth_pkg::SEL_ONE: mag = a_x1;
        booth_pkg::SEL_TWO: mag = a_x2;
        default:            mag = '0;
      endcase

      // Ones complement here, the +1 goes to the correction row
      row_val = digits[i][booth_pkg::DIGIT_NEG] ? ~mag : mag;

      // Inverted sign bit, the constant below removes the offset
      pp_rows[i] = {~row_val[mul_cfg_pkg::EXT_W-1], row_val[mul_cfg_pkg::EXT_W-2:0]};

      // Even bits carry the negation +1 of row i at weight 2i
      pp_rows[mul_cfg_pkg::ROW_NUM-1][2*i] = digits[i][booth_pkg::DIGIT_NEG];
      // Odd bits hold the sign extension constant
      // The tree places them at their real weights
      pp_rows[mul_cfg_pkg::ROW_NUM-1][2*i+1] = 1'b1;
    end
  end

endmodule

//--- src/csa_tree.sv
////////////////////////////////////////////////////////////
// Wallace carry-save tree
// Reduces all weighted rows to a sum row and a carry row
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module csa_tree (
  input  logic [mul_cfg_pkg::ROW_NUM-1:0][mul_cfg_pkg::EXT_W-1:0] pp_rows,
  output logic [mul_cfg_pkg::PROD_W-1:0]                         sum_row,
  output logic [mul_cfg_pkg::PROD_W-1:0]                         carry_row
);

  // Row count after lvl levels of 3:2 compression
  function automatic int rows_at(input int lvl);
    int n;
    n = mul_cfg_pkg::ROW_NUM;
    for (int l = 0; l < lvl; l++) begin
      n = 2 * (n / 3) + n % 3;
    end
    return n;
  endfunction

  // Levels needed to get down to two rows
  function automatic int tree_levels();
    int n;
    int lv;
    n  = mul_cfg_pkg::ROW_NUM;
    lv = 0;
    while (n > 2) begin
      n  = 2 * (n / 3) + n % 3;
      lv = lv + 1;
    end
    return lv;
  endfunction

  // Correction row to a full word
  // even bit 2i   -> weight 2i, negation carry
  // odd bit 2i+1  -> weight 2i+MUL_W+2, constant
  // top bit       -> weight MUL_W+1, constant
  // Anything past PROD_W falls off the shift
  function automatic logic [mul_cfg_pkg::PROD_W-1:0] spread_corr(
    input logic [mul_cfg_pkg::EXT_W-1:0] corr
  );
    logic [mul_cfg_pkg::PROD_W-1:0] w;
    w = '0;
    for (int i = 0; i < mul_cfg_pkg::PP_NUM - 1; i++) begin
      w = w | ({{(mul_cfg_pkg::PROD_W-1){1'b0}}, corr[2*i]} << (2*i));
      w = w | ({{(mul_cfg_pkg::PROD_W-1){1'b0}}, corr[2*i+1]}
               << (2*i + mul_cfg_pkg::MUL_W + 2));
    end
    w = w | ({{(mul_cfg_pkg::PROD_W-1){1'b0}}, corr[2*(mul_cfg_pkg::PP_NUM-1)]}
             << (2*(mul_cfg_pkg::PP_NUM-1)));
    w = w | ({{(mul_cfg_pkg::PROD_W-1){1'b0}}, corr[mul_cfg_pkg::EXT_W-1]}
             << (mul_cfg_pkg::MUL_W + 1));
    return w;
  endfunction

  // Rows per level, level 0 is the weighted input
  logic [mul_cfg_pkg::PROD_W-1:0] lvl_rows [0:tree_levels()][mul_cfg_pkg::ROW_NUM];

  ////////////////////////////////////////////////////////////
  // Row placement
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < mul_cfg_pkg::PP_NUM; i++) begin : g_place
    // Row i at weight 4^i, top bits truncated
    assign lvl_rows[0][i] = {{(mul_cfg_pkg::PROD_W-mul_cfg_pkg::EXT_W){1'b0}}, pp_rows[i]}
                            << (2*i);
  end
  assign lvl_rows[0][mul_cfg_pkg::ROW_NUM-1] = spread_corr(pp_rows[mul_cfg_pkg::ROW_NUM-1]);

  ////////////////////////////////////////////////////////////
  // 3:2 reduction levels
  ////////////////////////////////////////////////////////////

  for (genvar l = 0; l < tree_levels(); l++) begin : g_level
    // Full adders over each group of three rows
    for (genvar g = 0; g < rows_at(l) / 3; g++) begin : g_fa
      assign lvl_rows[l+1][2*g] = lvl_rows[l][3*g] ^ lvl_rows[l][3*g+1] ^ lvl_rows[l][3*g+2];
      assign lvl_rows[l+1][2*g+1] = ((lvl_rows[l][3*g]   & lvl_rows[l][3*g+1]) |
                                     (lvl_rows[l][3*g]   & lvl_rows[l][3*g+2]) |
                                     (lvl_rows[l][3*g+1] & lvl_rows[l][3*g+2])) << 1;
    end
    // Leftover rows go straight to the next level
    for (genvar r = 3 * (rows_at(l) / 3); r < rows_at(l); r++) begin : g_pass
      assign lvl_rows[l+1][r - (rows_at(l) / 3)] = lvl_rows[l][r];
    end
    // Slots no longer in use
    for (genvar r = rows_at(l+1); r < mul_cfg_pkg::ROW_NUM; r++) begin : g_idle
      assign lvl_rows[l+1][r] = '0;
    end
  end

  assign sum_row   = lvl_rows[tree_levels()][0];
  assign carry_row = lvl_rows[tree_levels()][1];

endmodule

//--- src/bk_adder.sv
////////////////////////////////////////////////////////////
// Brent-Kung prefix adder
// Carry-propagate sum of two rows with carry in and out
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module bk_adder (
  input  logic [mul_cfg_pkg::PROD_W-1:0] a,
  input  logic [mul_cfg_pkg::PROD_W-1:0] b,
  input  logic                           cin,
  output logic [mul_cfg_pkg::PROD_W-1:0] sum,
  output logic                           cout
);

  // Up-sweep depth
  function automatic int prefix_levels();
    return $clog2(mul_cfg_pkg::PROD_W);
  endfunction

  // Node distance of down-sweep step d
  function automatic int down_span(input int d);
    return 1 << (prefix_levels() - 2 - d);
  endfunction

  // Bitwise propagate
  logic [mul_cfg_pkg::PROD_W-1:0] p_bit;
  // Group generate per stage, up-sweep then down-sweep
  logic [mul_cfg_pkg::PROD_W-1:0] g_st [0:2*prefix_levels()-1];
  // Group propagate, only needed through the up-sweep
  logic [mul_cfg_pkg::PROD_W-1:0] p_st [0:prefix_levels()];
  // Carry into each bit
  logic [mul_cfg_pkg::PROD_W-1:0] carry;

  assign p_bit    = a ^ b;
  assign p_st[0]  = p_bit;
  // cin folded into bit 0 generate
  assign g_st[0]  = (a & b) | {{(mul_cfg_pkg::PROD_W-1){1'b0}}, p_bit[0] & cin};

  ////////////////////////////////////////////////////////////
  // Up-sweep
  ////////////////////////////////////////////////////////////

  for (genvar l = 0; l < prefix_levels(); l++) begin : g_up
    for (genvar i = 0; i < mul_cfg_pkg::PROD_W; i++) begin : g_bit
      if ((i + 1) % (2 << l) == 0) begin : g_op
        assign g_st[l+1][i] = g_st[l][i] | (p_st[l][i] & g_st[l][i - (1 << l)]);
        assign p_st[l+1][i] = p_st[l][i] & p_st[l][i - (1 << l)];
      end else begin : g_keep
        assign g_st[l+1][i] = g_st[l][i];
        assign p_st[l+1][i] = p_st[l][i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Down-sweep
  ////////////////////////////////////////////////////////////

  // Fill the prefixes the up-sweep left open, widest span first
  for (genvar d = 0; d < prefix_levels() - 1; d++) begin : g_down
    for (genvar i = 0; i < mul_cfg_pkg::PROD_W; i++) begin : g_bit
      if (((i + 1) % (2 * down_span(d)) == down_span(d)) &&
          (i >= 2 * down_span(d))) begin : g_op
        assign g_st[prefix_levels()+d+1][i] = g_st[prefix_levels()+d][i] |
            (p_st[prefix_levels()][i] & g_st[prefix_levels()+d][i - down_span(d)]);
      end else begin : g_keep
        assign g_st[prefix_levels()+d+1][i] = g_st[prefix_levels()+d][i];
      end
    end
  end

  // Sum bits, carry into bit i is the prefix up to i-1
  assign carry = {g_st[2*prefix_levels()-1][mul_cfg_pkg::PROD_W-2:0], cin};
  assign sum   = p_bit ^ carry;
  assign cout  = g_st[2*prefix_levels()-1][mul_cfg_pkg::PROD_W-1];

endmodule

//--- src/booth_wallace_mul.sv
////////////////////////////////////////////////////////////
// Booth-Wallace multiplier, two-stage pipeline
// Valid/ready handshake, stalls while the sink is not ready
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module booth_wallace_mul (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [mul_cfg_pkg::MUL_W-1:0]  op_a,
  input  logic [mul_cfg_pkg::MUL_W-1:0]  op_b,
  input  logic                           a_signed,
  input  logic                           b_signed,
  input  logic                           in_valid,
  output logic                           out_ready,
  input  logic                           in_ready,
  output logic                           out_valid,
  output logic [mul_cfg_pkg::PROD_W-1:0] product
);

  // Whole pipeline freezes on back-pressure
  logic stall;

  // Stage 1, partial product rows
  logic [mul_cfg_pkg::ROW_NUM-1:0][mul_cfg_pkg::EXT_W-1:0] pp_rows;
  logic [mul_cfg_pkg::ROW_NUM-1:0][mul_cfg_pkg::EXT_W-1:0] pp_rows_q;

  // Stage 2, carry-save pair
  logic [mul_cfg_pkg::PROD_W-1:0] sum_row;
  logic [mul_cfg_pkg::PROD_W-1:0] carry_row;
  logic [mul_cfg_pkg::PROD_W-1:0] sum_row_q;
  logic [mul_cfg_pkg::PROD_W-1:0] carry_row_q;

  // Valid flag, one bit per stage
  logic [mul_cfg_pkg::PIPE_DEPTH-1:0] valid_sr;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  assign stall     = ~in_ready;
  // Source sees the sink's ready directly
  assign out_ready = in_ready;
  assign out_valid = valid_sr[mul_cfg_pkg::PIPE_DEPTH-1];

  // Bubbles shift through as zeros
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_sr <= '0;
    end else if (!stall) begin
      valid_sr <= {valid_sr[mul_cfg_pkg::PIPE_DEPTH-2:0], in_valid};
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 1
  ////////////////////////////////////////////////////////////

  booth4_pp_gen u_pp_gen (
    .op_a     (op_a),
    .op_b     (op_b),
    .a_signed (a_signed),
    .b_signed (b_signed),
    .pp_rows  (pp_rows)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pp_rows_q <= '0;
    end else if (!stall) begin
      pp_rows_q <= pp_rows;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2
  ////////////////////////////////////////////////////////////

  csa_tree u_csa_tree (
    .pp_rows   (pp_rows_q),
    .sum_row   (sum_row),
    .carry_row (carry_row)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_row_q   <= '0;
      carry_row_q <= '0;
    end else if (!stall) begin
      sum_row_q   <= sum_row;
      carry_row_q <= carry_row;
    end
  end

  ////////////////////////////////////////////////////////////
  // Final add
  ////////////////////////////////////////////////////////////

  // Product always fits, carry out not needed here
  bk_adder u_bk_adder (
    .a    (sum_row_q),
    .b    (carry_row_q),
    .cin  (1'b0),
    .sum  (product),
    .cout ()
  );

endmodule

//--- verif/mul_checker.sv
////////////////////////////////////////////////////////////
// Multiplier result checker
// Queues accepted operands, compares delivered products
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module mul_checker (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [mul_cfg_pkg::MUL_W-1:0]  op_a,
  input  logic [mul_cfg_pkg::MUL_W-1:0]  op_b,
  input  logic                           a_signed,
  input  logic                           b_signed,
  input  logic                           in_valid,
  input  logic                           out_ready,
  input  logic                           in_ready,
  input  logic                           out_valid,
  input  logic [mul_cfg_pkg::PROD_W-1:0] product,
  input  logic                           ref_known,
  input  logic [mul_cfg_pkg::PROD_W-1:0] ref_product,
  output int                             pending,
  output int                             value_errs,
  output int                             proto_errs
);

  // Entry {ref_known, ref_product, a_signed, b_signed, op_a, op_b}
  localparam int ITEM_W = 3 + mul_cfg_pkg::PROD_W + 2 * mul_cfg_pkg::MUL_W;

  logic [ITEM_W-1:0] inflight [$];
  // Expected out_valid, one bit per stage
  logic [mul_cfg_pkg::PIPE_DEPTH-1:0] valid_model = '0;
  logic                               held = 1'b0;
  logic [mul_cfg_pkg::PROD_W-1:0]     held_product = '0;
  int n_pending = 0;
  int n_value   = 0;
  int n_proto   = 0;

  assign pending    = n_pending;
  assign value_errs = n_value;
  assign proto_errs = n_proto;

  // Zero or sign extend both operands, keep the low product bits
  function automatic logic [mul_cfg_pkg::PROD_W-1:0] expect_product(
    input logic [mul_cfg_pkg::MUL_W-1:0] a,
    input logic [mul_cfg_pkg::MUL_W-1:0] b,
    input logic                          sa,
    input logic                          sb
  );
    logic [mul_cfg_pkg::PROD_W-1:0] ax;
    logic [mul_cfg_pkg::PROD_W-1:0] bx;
    ax = {{mul_cfg_pkg::MUL_W{sa & a[mul_cfg_pkg::MUL_W-1]}}, a};
    bx = {{mul_cfg_pkg::MUL_W{sb & b[mul_cfg_pkg::MUL_W-1]}}, b};
    return ax * bx;
  endfunction

  // Falling edge, inputs and outputs both settled for the next rising edge
  always @(negedge clk) begin : watch
    logic [ITEM_W-1:0]              item;
    logic                           known;
    logic [mul_cfg_pkg::PROD_W-1:0] ref_val;
    logic                           sa;
    logic                           sb;
    logic [mul_cfg_pkg::MUL_W-1:0]  a;
    logic [mul_cfg_pkg::MUL_W-1:0]  b;
    logic [mul_cfg_pkg::PROD_W-1:0] exp_val;
    if (!rst_n) begin
      if (out_valid !== 1'b0) begin
        n_proto++;
        $display("FAIL t=%0t: out_valid is %b during reset", $time, out_valid);
      end
      valid_model = '0;
      held        = 1'b0;
    end else begin
      // Two-cycle latency, bubbles and stalls
      if (out_valid !== valid_model[mul_cfg_pkg::PIPE_DEPTH-1]) begin
        n_proto++;
        $display("FAIL t=%0t: out_valid is %b, latency model says %b", $time, out_valid,
                 valid_model[mul_cfg_pkg::PIPE_DEPTH-1]);
      end
      // Result held under back-pressure
      if (held && (out_valid !== 1'b1 || product !== held_product)) begin
        n_proto++;
        $display("FAIL t=%0t: held result changed to %h from %h", $time, product,
                 held_product);
      end
      held         = out_valid & ~in_ready;
      held_product = product;
      // Oldest item leaves first
      if (out_valid && in_ready) begin
        if (inflight.size() == 0) begin
          n_proto++;
          $display("Unexpected result %h appeared at time %0t with nothing in flight",
                   product, $time);
        end else begin
          item = inflight.pop_front();
          {known, ref_val, sa, sb, a, b} = item;
          exp_val = expect_product(a, b, sa, sb);
          if (product !== exp_val) begin
            n_value++;
            $display("FAIL t=%0t: a=%h(s%b) b=%h(s%b) expected %h got %h", $time, a, sa, b,
                     sb, exp_val, product);
          end
          if (known && product !== ref_val) begin
            n_value++;
            $display("FAIL t=%0t: a=%h b=%h table value %h got %h", $time, a, b, ref_val,
                     product);
          end
        end
      end
      if (in_valid && out_ready) begin
        inflight.push_back({ref_known, ref_product, a_signed, b_signed, op_a, op_b});
      end
      if (in_ready) begin
        valid_model = {valid_model[mul_cfg_pkg::PIPE_DEPTH-2:0], in_valid};
      end
    end
    n_pending = inflight.size();
  end

endmodule

//--- verif/booth_wallace_mul_sva.sv
////////////////////////////////////////////////////////////
// Multiplier assertions
// Reset state, stall hold, ready pass-through, digit codes
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module booth_wallace_mul_sva (
  input logic                                                   clk,
  input logic                                                   rst_n,
  input logic                                                   in_ready,
  input logic                                                   out_ready,
  input logic                                                   out_valid,
  input logic [mul_cfg_pkg::PROD_W-1:0]                         product,
  input logic [mul_cfg_pkg::PP_NUM-1:0][booth_pkg::DIGIT_W-1:0] digits
);

  // Failures per assertion
  int n_rst   = 0;
  int n_hold  = 0;
  int n_ready = 0;
  int n_digit = 0;
  int fail_count;

  assign fail_count = n_rst + n_hold + n_ready + n_digit;

  // Some digit asks for x1 and x2 at once
  function automatic logic double_select(
    input logic [mul_cfg_pkg::PP_NUM-1:0][booth_pkg::DIGIT_W-1:0] d
  );
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < mul_cfg_pkg::PP_NUM; i++) begin
      hit = hit | (((d[i][1:0] & booth_pkg::SEL_ONE) != 2'b00) &&
                   ((d[i][1:0] & booth_pkg::SEL_TWO) != 2'b00));
    end
    return hit;
  endfunction

  a_reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else begin
      n_rst++;
      $error("out_valid high while reset is active");
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !in_ready |=> $stable(product) && $stable(out_valid))
    else begin
      n_hold++;
      $error("product or out_valid moved during a stall");
    end

  a_ready_pass: assert property (@(posedge clk) out_ready == in_ready)
    else begin
      n_ready++;
      $error("out_ready differs from in_ready");
    end

  a_digit_sel: assert property (@(posedge clk) disable iff (!rst_n) !double_select(digits))
    else begin
      n_digit++;
      $error("Booth digit selects both x1 and x2");
    end

endmodule

bind booth_wallace_mul booth_wallace_mul_sva u_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_ready  (in_ready),
  .out_ready (out_ready),
  .out_valid (out_valid),
  .product   (product),
  .digits    (u_pp_gen.digits)
);

//--- verif/booth_wallace_mul_tb.sv
////////////////////////////////////////////////////////////
// Booth-Wallace multiplier testbench
// Corner table, then random operands under random back-pressure
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module booth_wallace_mul_tb;

  localparam int TAB_LEN  = 17;
  localparam int RAND_LEN = 200;

  // {op_a, op_b, a_signed, b_signed, stall, product}
  localparam logic [66:0] STIM_TAB [TAB_LEN] = '{
    // Unsigned corners, back to back
    {16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0, 32'h0000_0000},
    {16'hffff, 16'hffff, 1'b0, 1'b0, 1'b0, 32'hfffe_0001},
    {16'h0001, 16'hffff, 1'b0, 1'b0, 1'b0, 32'h0000_ffff},
    {16'haaaa, 16'h5555, 1'b0, 1'b0, 1'b0, 32'h38e3_1c72},
    {16'haaaa, 16'haaaa, 1'b0, 1'b0, 1'b0, 32'h71c6_38e4},
    {16'h1234, 16'h5678, 1'b0, 1'b0, 1'b0, 32'h0626_0060},
    // Signed corners
    {16'h8000, 16'h8000, 1'b1, 1'b1, 1'b0, 32'h4000_0000},
    {16'h8000, 16'hffff, 1'b1, 1'b1, 1'b1, 32'h0000_8000},
    {16'hffff, 16'hffff, 1'b1, 1'b1, 1'b0, 32'h0000_0001},
    {16'h7fff, 16'h7fff, 1'b1, 1'b1, 1'b0, 32'h3fff_0001},
    {16'h7fff, 16'h8000, 1'b1, 1'b1, 1'b1, 32'hc000_8000},
    {16'h1234, 16'hfffe, 1'b1, 1'b1, 1'b0, 32'hffff_db98},
    // Mixed flags
    {16'hffff, 16'hffff, 1'b1, 1'b0, 1'b0, 32'hffff_0001},
    {16'h8000, 16'hffff, 1'b1, 1'b0, 1'b1, 32'h8000_8000},
    {16'hffff, 16'h8000, 1'b0, 1'b1, 1'b0, 32'h8000_8000},
    // Stalled pairs
    {16'h5555, 16'haaaa, 1'b0, 1'b0, 1'b1, 32'h38e3_1c72},
    {16'hffff, 16'h0002, 1'b0, 1'b0, 1'b1, 32'h0001_fffe}
  };

  logic clk = 1'b0;
  logic rst_n;
  logic [mul_cfg_pkg::MUL_W-1:0]  op_a;
  logic [mul_cfg_pkg::MUL_W-1:0]  op_b;
  logic                           a_signed;
  logic                           b_signed;
  logic                           in_valid;
  logic                           in_ready;
  logic                           out_ready;
  logic                           out_valid;
  logic [mul_cfg_pkg::PROD_W-1:0] product;
  // Table value for the pair on the inputs
  logic                           ref_known;
  logic [mul_cfg_pkg::PROD_W-1:0] ref_product;
  int     pending;
  int     value_errs;
  int     proto_errs;
  int     n_timeout = 0;
  int     n_missing = 0;
  integer seed;
  // Random ready and bubbles only after the table
  logic   rand_mode = 1'b0;

  always #5 clk = ~clk;

  booth_wallace_mul u_booth_wallace_mul (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_a      (op_a),
    .op_b      (op_b),
    .a_signed  (a_signed),
    .b_signed  (b_signed),
    .in_valid  (in_valid),
    .out_ready (out_ready),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .product   (product)
  );

  mul_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .op_a        (op_a),
    .op_b        (op_b),
    .a_signed    (a_signed),
    .b_signed    (b_signed),
    .in_valid    (in_valid),
    .out_ready   (out_ready),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .product     (product),
    .ref_known   (ref_known),
    .ref_product (ref_product),
    .pending     (pending),
    .value_errs  (value_errs),
    .proto_errs  (proto_errs)
  );

  // Sink ready, high three times in four when random
  function automatic logic pick_ready();
    logic [31:0] r;
    if (!rand_mode) begin
      return 1'b1;
    end
    r = $random(seed);
    return r[1:0] != 2'b00;
  endfunction

  ////////////////////////////////////////////////////////////
  // Drive one pair until it is taken
  ////////////////////////////////////////////////////////////

  task automatic send_pair(
    input logic [15:0] a,
    input logic [15:0] b,
    input logic        sa,
    input logic        sb,
    input logic        stall,
    input logic        known,
    input logic [31:0] expv
  );
    logic taken;
    int   waited;
    op_a        = a;
    op_b        = b;
    a_signed    = sa;
    b_signed    = sb;
    ref_known   = known;
    ref_product = expv;
    in_valid    = 1'b1;
    // Stalled entry starts with the sink not ready
    in_ready    = stall ? 1'b0 : pick_ready();
    taken       = 1'b0;
    waited      = 0;
    while (!taken && waited < 64) begin
      taken = in_ready;
      @(posedge clk);
      #1;
      waited++;
      if (!taken) begin
        in_ready = pick_ready();
      end
    end
    in_valid = 1'b0;
    if (!taken) begin
      n_timeout++;
      $display("Timeout: pair a=%h b=%h was never accepted", a, b);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    logic [66:0] ent;
    logic [31:0] ra;
    logic [31:0] rb;
    int          waited;
    int          total;
    seed        = 32'hbf15;
    rst_n       = 1'b0;
    op_a        = '0;
    op_b        = '0;
    a_signed    = 1'b0;
    b_signed    = 1'b0;
    in_valid    = 1'b0;
    in_ready    = 1'b1;
    ref_known   = 1'b0;
    ref_product = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Idle cycles, out_valid must stay low
    repeat (3) begin
      @(posedge clk);
      #1;
    end
    for (int i = 0; i < TAB_LEN; i++) begin
      if (n_timeout != 0) break;
      ent = STIM_TAB[i];
      send_pair(ent[66:51], ent[50:35], ent[34], ent[33], ent[32], 1'b1, ent[31:0]);
    end
    rand_mode = 1'b1;
    for (int n = 0; n < RAND_LEN; n++) begin
      if (n_timeout != 0) break;
      ra = $random(seed);
      rb = $random(seed);
      send_pair(ra[15:0], rb[15:0], ra[16], rb[16], 1'b0, 1'b0, 32'h0);
      // Occasional bubble
      if (rb[31:30] == 2'b00) begin
        in_ready = pick_ready();
        @(posedge clk);
        #1;
      end
    end
    // Drain with the sink always ready
    in_ready = 1'b1;
    waited   = 0;
    while (pending != 0 && waited < 100) begin
      @(posedge clk);
      waited++;
    end
    if (pending != 0) begin
      n_missing = pending;
      $display("Timeout: %0d results went missing after the last input", pending);
    end
    repeat (2) @(posedge clk);
    total = value_errs + proto_errs + u_booth_wallace_mul.u_sva.fail_count + n_timeout +
            n_missing;
    $display("Errors: value %0d, protocol %0d, assertion %0d, timeout %0d, missing %0d",
             value_errs, proto_errs, u_booth_wallace_mul.u_sva.fail_count, n_timeout,
             n_missing);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- booth_wallace_mul.f
src/mul_cfg_pkg.sv
src/booth_pkg.sv
src/booth4_pp_gen.sv
src/csa_tree.sv
src/bk_adder.sv
src/booth_wallace_mul.sv
verif/mul_checker.sv
verif/booth_wallace_mul_sva.sv
verif/booth_wallace_mul_tb.sv

//--- Makefile
# Verilator simulation of the Booth-Wallace multiplier

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module booth_wallace_mul_tb \
		-f booth_wallace_mul.f --Mdir obj_dir
	./obj_dir/Vbooth_wallace_mul_tb | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
